/* verilog/axi_bridge_defines.svh */
`ifndef AXI_BRIDGE_DEFINES_SVH
`define AXI_BRIDGE_DEFINES_SVH

// data path
`define WORD_W 32
`define ADDR_W 32

// axi transaction id width
`define ID_W 4

// words per cache line
`define INST_LINE_WORDS 8
`define DATA_LINE_WORDS 4

// byte offset bits inside a data line
`define DATA_OFFSET_W 4

// fixed ids per requester, data writes share the data id
`define INST_ID 0
`define DATA_ID 1

`endif

/* verilog/axi_bridge_pkg.sv */
`include "axi_bridge_defines.svh"

package axi_bridge_pkg;

    typedef logic [`WORD_W-1:0]                   word_t;
    typedef logic [`ADDR_W-1:0]                   addr_t;
    typedef logic [`WORD_W/8-1:0]                 strb_t;
    typedef logic [`ID_W-1:0]                     axi_id_t;
    typedef logic [7:0]                           axi_len_t;
    typedef logic [2:0]                           axi_size_t;
    typedef logic [`INST_LINE_WORDS*`WORD_W-1:0]  inst_line_t;
    typedef logic [`DATA_LINE_WORDS*`WORD_W-1:0]  data_line_t;

    // address channel, shared by ar and aw
    typedef struct packed {
        axi_id_t   id;
        addr_t     addr;
        axi_len_t  len;
        axi_size_t size;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t    id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t    id;
        logic [1:0] resp;
    } axi_b_t;

    // line currently owned by the write side
    typedef struct packed {
        logic                              busy;
        logic [`ADDR_W-`DATA_OFFSET_W-1:0] line;
    } wr_pending_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_RET
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } wr_state_e;

endpackage

/* verilog/rd_channel.sv */
`timescale 1ns/10ps
`include "axi_bridge_defines.svh"

module rd_channel
    import axi_bridge_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,

    input  logic        inst_rd_req,
    input  addr_t       inst_rd_addr,
    output logic        inst_rd_rdy,
    output logic        inst_ret_valid,
    output inst_line_t  inst_ret_data,

    input  logic        data_rd_req,
    input  logic        data_rd_type,
    input  addr_t       data_rd_addr,
    input  axi_size_t   data_rd_size,
    output logic        data_rd_rdy,
    output logic        data_ret_valid,
    output data_line_t  data_ret_data,

    input  wr_pending_t wr_pending,

    output axi_ar_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  axi_r_t      r,
    input  logic        rvalid,
    output logic        rready
);

    localparam int INST_OFFSET_W = $clog2(`INST_LINE_WORDS * `WORD_W / 8);
    localparam int BEAT_W = $clog2(`INST_LINE_WORDS);
    localparam axi_size_t WORD_SIZE = axi_size_t'($clog2(`WORD_W / 8));

    rd_state_e         state;
    logic [BEAT_W-1:0] beat;
    logic              grant_data;
    axi_ar_t           ar_q;
    inst_line_t        line_q;

    logic data_hazard;
    logic data_take;
    logic inst_take;

    // data read to the line under write must wait for wr_ok
    always_comb begin
        data_hazard = wr_pending.busy &&
                      (data_rd_addr[`ADDR_W-1:`DATA_OFFSET_W] == wr_pending.line);
        data_take   = (state == RD_IDLE) && data_rd_req && !data_hazard;
        inst_take   = (state == RD_IDLE) && inst_rd_req && !data_take;
    end

    // fixed priority, data first
    assign data_rd_rdy = (state == RD_IDLE) && !data_hazard;
    assign inst_rd_rdy = (state == RD_IDLE) && !data_take;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= RD_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (data_take || inst_take) begin
                        state <= RD_ADDR;
                        beat  <= '0;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            state <= RD_RET;
                        end
                    end
                end
                RD_RET: begin
                    state <= RD_IDLE;
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // request payload and collected line
    always_ff @(posedge aclk) begin
        if (data_take) begin
            grant_data <= 1'b1;
            ar_q.id    <= axi_id_t'(`DATA_ID);
            if (data_rd_type) begin
                ar_q.addr <= {data_rd_addr[`ADDR_W-1:`DATA_OFFSET_W],
                              {`DATA_OFFSET_W{1'b0}}};
                ar_q.len  <= axi_len_t'(`DATA_LINE_WORDS - 1);
                ar_q.size <= WORD_SIZE;
            end else begin
                ar_q.addr <= data_rd_addr;
                ar_q.len  <= '0;
                ar_q.size <= data_rd_size;
            end
        end else if (inst_take) begin
            grant_data <= 1'b0;
            ar_q.id    <= axi_id_t'(`INST_ID);
            ar_q.addr  <= {inst_rd_addr[`ADDR_W-1:INST_OFFSET_W], {INST_OFFSET_W{1'b0}}};
            ar_q.len   <= axi_len_t'(`INST_LINE_WORDS - 1);
            ar_q.size  <= WORD_SIZE;
        end
        if (state == RD_DATA && rvalid) begin
            line_q[beat*`WORD_W +: `WORD_W] <= r.data;
        end
    end

    assign ar      = ar_q;
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    assign inst_ret_valid = (state == RD_RET) && !grant_data;
    assign data_ret_valid = (state == RD_RET) && grant_data;
    assign inst_ret_data  = line_q;
    assign data_ret_data  = line_q[`DATA_LINE_WORDS*`WORD_W-1:0];

    ar_stable: assert property (@(posedge aclk) disable iff (rst)
        arvalid && !arready |=> $stable(ar));

    // a return always follows the last beat of its burst
    ret_after_last: assert property (@(posedge aclk) disable iff (rst)
        (inst_ret_valid || data_ret_valid) |->
            (state == RD_RET) && $past(rvalid && rready && r.last));

endmodule

/* verilog/wr_channel.sv */
`timescale 1ns/10ps
`include "axi_bridge_defines.svh"

module wr_channel
    import axi_bridge_pkg::*;
(
    input  logic        aclk,
    input  logic        rst,

    input  logic        data_wr_req,
    input  logic        data_wr_type,
    input  addr_t       data_wr_addr,
    input  strb_t       data_wr_strb,
    input  data_line_t  data_wr_data,
    output logic        data_wr_rdy,
    output logic        data_wr_ok,

    output wr_pending_t wr_pending,

    output axi_ar_t     aw,
    output logic        awvalid,
    input  logic        awready,
    output axi_w_t      w,
    output logic        wvalid,
    input  logic        wready,
    input  axi_b_t      b,
    input  logic        bvalid,
    output logic        bready
);

    localparam int BEAT_W = $clog2(`DATA_LINE_WORDS);
    localparam axi_size_t WORD_SIZE = axi_size_t'($clog2(`WORD_W / 8));

    wr_state_e         state;
    logic [BEAT_W-1:0] beat;
    axi_ar_t           aw_q;
    strb_t             strb_q;
    data_line_t        line_q;
    logic              wr_take;
    logic              last_beat;

    assign data_wr_rdy = (state == WR_IDLE);
    assign wr_take     = data_wr_req && data_wr_rdy;
    assign last_beat   = (axi_len_t'(beat) == aw_q.len);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= WR_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_take) begin
                        state <= WR_ADDR;
                        beat  <= '0;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        state <= WR_DONE;
                    end
                end
                WR_DONE: begin
                    state <= WR_IDLE;
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // a line write always carries full strobes
    always_ff @(posedge aclk) begin
        if (wr_take) begin
            line_q    <= data_wr_data;
            aw_q.id   <= axi_id_t'(`DATA_ID);
            aw_q.size <= WORD_SIZE;
            if (data_wr_type) begin
                aw_q.addr <= {data_wr_addr[`ADDR_W-1:`DATA_OFFSET_W],
                              {`DATA_OFFSET_W{1'b0}}};
                aw_q.len  <= axi_len_t'(`DATA_LINE_WORDS - 1);
                strb_q    <= '1;
            end else begin
                aw_q.addr <= data_wr_addr;
                aw_q.len  <= '0;
                strb_q    <= data_wr_strb;
            end
        end
    end

    assign aw      = aw_q;
    assign awvalid = (state == WR_ADDR);
    assign wvalid  = (state == WR_DATA);
    assign bready  = (state == WR_RESP);

    always_comb begin
        w.data = line_q[beat*`WORD_W +: `WORD_W];
        w.strb = strb_q;
        w.last = last_beat;
    end

    assign data_wr_ok = (state == WR_DONE);

    // covers the accept cycle too, so a same-cycle read sees the hazard
    always_comb begin
        wr_pending.busy = (state != WR_IDLE) || data_wr_req;
        if (state == WR_IDLE) begin
            wr_pending.line = data_wr_addr[`ADDR_W-1:`DATA_OFFSET_W];
        end else begin
            wr_pending.line = aw_q.addr[`ADDR_W-1:`DATA_OFFSET_W];
        end
    end

    w_after_aw: assert property (@(posedge aclk) disable iff (rst)
        $rose(wvalid) |-> $past(awvalid && awready));

endmodule

/* verilog/axi_bridge_top.sv */
`timescale 1ns/10ps

module axi_bridge_top
    import axi_bridge_pkg::*;
(
    input  logic       aclk,
    input  logic       rst,

    // instruction cache refill
    input  logic       inst_rd_req,
    input  addr_t      inst_rd_addr,
    output logic       inst_rd_rdy,
    output logic       inst_ret_valid,
    output inst_line_t inst_ret_data,

    // data cache refill and uncached reads
    input  logic       data_rd_req,
    input  logic       data_rd_type,
    input  addr_t      data_rd_addr,
    input  axi_size_t  data_rd_size,
    output logic       data_rd_rdy,
    output logic       data_ret_valid,
    output data_line_t data_ret_data,

    // data cache write-back and uncached writes
    input  logic       data_wr_req,
    input  logic       data_wr_type,
    input  addr_t      data_wr_addr,
    input  strb_t      data_wr_strb,
    input  data_line_t data_wr_data,
    output logic       data_wr_rdy,
    output logic       data_wr_ok,

    // axi master
    output axi_ar_t    ar,
    output logic       arvalid,
    input  logic       arready,
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    output axi_ar_t    aw,
    output logic       awvalid,
    input  logic       awready,
    output axi_w_t     w,
    output logic       wvalid,
    input  logic       wready,
    input  axi_b_t     b,
    input  logic       bvalid,
    output logic       bready
);

    wr_pending_t wr_pending;

    rd_channel u_rd_channel (
        .aclk           (aclk),
        .rst            (rst),
        .inst_rd_req    (inst_rd_req),
        .inst_rd_addr   (inst_rd_addr),
        .inst_rd_rdy    (inst_rd_rdy),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret_data  (inst_ret_data),
        .data_rd_req    (data_rd_req),
        .data_rd_type   (data_rd_type),
        .data_rd_addr   (data_rd_addr),
        .data_rd_size   (data_rd_size),
        .data_rd_rdy    (data_rd_rdy),
        .data_ret_valid (data_ret_valid),
        .data_ret_data  (data_ret_data),
        .wr_pending     (wr_pending),
        .ar             (ar),
        .arvalid        (arvalid),
        .arready        (arready),
        .r              (r),
        .rvalid         (rvalid),
        .rready         (rready)
    );

    wr_channel u_wr_channel (
        .aclk         (aclk),
        .rst          (rst),
        .data_wr_req  (data_wr_req),
        .data_wr_type (data_wr_type),
        .data_wr_addr (data_wr_addr),
        .data_wr_strb (data_wr_strb),
        .data_wr_data (data_wr_data),
        .data_wr_rdy  (data_wr_rdy),
        .data_wr_ok   (data_wr_ok),
        .wr_pending   (wr_pending),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .b            (b),
        .bvalid       (bvalid),
        .bready       (bready)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic aclk,
    output logic rst
);

    // 20 ns period
    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // reset held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge aclk);
        rst <= 1'b0;
    end

endmodule

/* verif/axi_slave_model.sv */
`timescale 1ns/10ps

module axi_slave_model
    import axi_bridge_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic    aclk,
    input  logic    rst,
    input  int      b_delay,

    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,

    input  axi_ar_t aw,
    input  logic    awvalid,
    output logic    awready,
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    axi_len_t         rd_left;
    logic             wr_resp;
    int               b_wait;

    // byte address of the word with its upper half inverted
    function automatic word_t fill_word(int i);
        addr_t a;
        a = addr_t'(i) << 2;
        return {~a[31:16], a[15:0]};
    endfunction

    always @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= fill_word(i);
            end
            arready <= 1'b1;
            rvalid  <= 1'b0;
            r       <= '0;
            rd_idx  <= '0;
            rd_left <= '0;
            awready <= 1'b1;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            b       <= '0;
            wr_idx  <= '0;
            wr_resp <= 1'b0;
            b_wait  <= 0;
        end else begin
            // read bursts, one beat per rready
            if (arvalid && arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                rd_idx  <= ar.addr[IDX_W+1:2] + 1'b1;
                rd_left <= ar.len;
                r.id    <= ar.id;
                r.data  <= mem[ar.addr[IDX_W+1:2]];
                r.resp  <= 2'b00;
                r.last  <= (ar.len == 8'd0);
            end else if (rvalid && rready) begin
                if (r.last) begin
                    rvalid  <= 1'b0;
                    arready <= 1'b1;
                end else begin
                    rd_idx  <= rd_idx + 1'b1;
                    rd_left <= rd_left - 1'b1;
                    r.data  <= mem[rd_idx];
                    r.last  <= (rd_left == 8'd1);
                end
            end

            // write bursts merged under strobes, then a delayed response
            if (awvalid && awready) begin
                awready <= 1'b0;
                wready  <= 1'b1;
                wr_idx  <= aw.addr[IDX_W+1:2];
                b.id    <= aw.id;
                b.resp  <= 2'b00;
            end else if (wvalid && wready) begin
                for (int k = 0; k < 4; k++) begin
                    if (w.strb[k]) begin
                        mem[wr_idx][8*k +: 8] <= w.data[8*k +: 8];
                    end
                end
                wr_idx <= wr_idx + 1'b1;
                if (w.last) begin
                    wready  <= 1'b0;
                    wr_resp <= 1'b1;
                    b_wait  <= b_delay;
                end
            end else if (bvalid && bready) begin
                bvalid  <= 1'b0;
                wr_resp <= 1'b0;
                awready <= 1'b1;
            end else if (wr_resp && !bvalid) begin
                if (b_wait > 0) begin
                    b_wait <= b_wait - 1;
                end else begin
                    bvalid <= 1'b1;
                end
            end
        end
    end

endmodule

/* verif/tb_axi_bridge.sv */
`timescale 1ns/10ps
`include "axi_bridge_defines.svh"

module tb_axi_bridge
    import axi_bridge_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic       aclk;
    logic       rst;
    logic       inst_rd_req;
    addr_t      inst_rd_addr;
    logic       inst_rd_rdy;
    logic       inst_ret_valid;
    inst_line_t inst_ret_data;
    logic       data_rd_req;
    logic       data_rd_type;
    addr_t      data_rd_addr;
    axi_size_t  data_rd_size;
    logic       data_rd_rdy;
    logic       data_ret_valid;
    data_line_t data_ret_data;
    logic       data_wr_req;
    logic       data_wr_type;
    addr_t      data_wr_addr;
    strb_t      data_wr_strb;
    data_line_t data_wr_data;
    logic       data_wr_rdy;
    logic       data_wr_ok;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    axi_ar_t    aw;
    logic       awvalid;
    logic       awready;
    axi_w_t     w;
    logic       wvalid;
    logic       wready;
    axi_b_t     b;
    logic       bvalid;
    logic       bready;
    int         b_delay;

    // observed bus events
    axi_ar_t ar_log[$];
    axi_ar_t aw_log[$];
    int      cycle = 0;
    int      wr_ok_count = 0;
    int      wr_ok_cycle = 0;

    tb_clock_gen u_clk (
        .aclk (aclk),
        .rst  (rst)
    );

    axi_bridge_top uut (
        .aclk           (aclk),
        .rst            (rst),
        .inst_rd_req    (inst_rd_req),
        .inst_rd_addr   (inst_rd_addr),
        .inst_rd_rdy    (inst_rd_rdy),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret_data  (inst_ret_data),
        .data_rd_req    (data_rd_req),
        .data_rd_type   (data_rd_type),
        .data_rd_addr   (data_rd_addr),
        .data_rd_size   (data_rd_size),
        .data_rd_rdy    (data_rd_rdy),
        .data_ret_valid (data_ret_valid),
        .data_ret_data  (data_ret_data),
        .data_wr_req    (data_wr_req),
        .data_wr_type   (data_wr_type),
        .data_wr_addr   (data_wr_addr),
        .data_wr_strb   (data_wr_strb),
        .data_wr_data   (data_wr_data),
        .data_wr_rdy    (data_wr_rdy),
        .data_wr_ok     (data_wr_ok),
        .ar             (ar),
        .arvalid        (arvalid),
        .arready        (arready),
        .r              (r),
        .rvalid         (rvalid),
        .rready         (rready),
        .aw             (aw),
        .awvalid        (awvalid),
        .awready        (awready),
        .w              (w),
        .wvalid         (wvalid),
        .wready         (wready),
        .b              (b),
        .bvalid         (bvalid),
        .bready         (bready)
    );

    axi_slave_model u_mem (
        .aclk    (aclk),
        .rst     (rst),
        .b_delay (b_delay),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    always @(posedge aclk) begin
        cycle <= cycle + 1;
        if (arvalid && arready) begin
            ar_log.push_back(ar);
        end
        if (awvalid && awready) begin
            aw_log.push_back(aw);
        end
        if (data_wr_ok) begin
            wr_ok_count <= wr_ok_count + 1;
            wr_ok_cycle <= cycle;
        end
    end

    // initial memory contents for the word holding byte address a
    function automatic word_t expected_word(addr_t a);
        return {~a[31:16], a[15:2], 2'b00};
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t s);
        word_t res;
        res = old_w;
        for (int k = 0; k < 4; k++) begin
            if (s[k]) begin
                res[8*k +: 8] = new_w[8*k +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped on a wrong value");
    endtask

    task automatic report_timeout(input string msg);
        $display("timed out: %s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped on a timeout");
    endtask

    task automatic drive_inst_read(input addr_t a, output inst_line_t got);
        int n;
        @(posedge aclk);
        inst_rd_req  <= 1'b1;
        inst_rd_addr <= a;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge aclk);
            if (inst_rd_rdy) break;
        end
        assert (n < TIMEOUT) else report_timeout("instruction read was never accepted");
        inst_rd_req <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge aclk);
            if (inst_ret_valid) break;
        end
        assert (n < TIMEOUT) else report_timeout("instruction line never came back");
        got = inst_ret_data;
    endtask

    task automatic drive_data_read(input addr_t a, input logic line, input axi_size_t sz,
                                   output data_line_t got, output int ret_cycle);
        int n;
        @(posedge aclk);
        data_rd_req  <= 1'b1;
        data_rd_type <= line;
        data_rd_addr <= a;
        data_rd_size <= sz;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge aclk);
            if (data_rd_rdy) break;
        end
        assert (n < TIMEOUT) else report_timeout("data read was never accepted");
        data_rd_req <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge aclk);
            if (data_ret_valid) break;
        end
        assert (n < TIMEOUT) else report_timeout("data read never came back");
        got       = data_ret_data;
        ret_cycle = cycle;
    endtask

    // returns once the write is accepted, not at wr_ok
    task automatic drive_write(input addr_t a, input logic line, input strb_t s,
                               input data_line_t d);
        int n;
        @(posedge aclk);
        data_wr_req  <= 1'b1;
        data_wr_type <= line;
        data_wr_addr <= a;
        data_wr_strb <= s;
        data_wr_data <= d;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge aclk);
            if (data_wr_rdy) break;
        end
        assert (n < TIMEOUT) else report_timeout("data write was never accepted");
        data_wr_req <= 1'b0;
    endtask

    task automatic inst_refill();
        addr_t      a;
        inst_line_t got;
        word_t      exp;
        a = $urandom & 32'h3fc;
        ar_log.delete();
        drive_inst_read(a, got);
        for (int k = 0; k < 8; k++) begin
            exp = expected_word({a[31:5], 5'b0} + addr_t'(4 * k));
            assert (got[32*k +: 32] == exp) else report_mismatch(
                $sformatf("inst word %0d got %h exp %h", k, got[32*k +: 32], exp));
        end
        assert (ar_log.size() == 1 && ar_log[0].id == axi_id_t'(`INST_ID)
                && ar_log[0].len == 8'd7 && ar_log[0].size == 3'd2)
            else report_mismatch("instruction read used a wrong arid, arlen or arsize");
    endtask

    task automatic uncached_read();
        addr_t      a;
        axi_size_t  sz;
        data_line_t got;
        int         c;
        a  = $urandom & 32'h3fc;
        sz = axi_size_t'($urandom % 3);
        ar_log.delete();
        drive_data_read(a, 1'b0, sz, got, c);
        assert (got[31:0] == expected_word(a)) else report_mismatch(
            $sformatf("single read got %h exp %h", got[31:0], expected_word(a)));
        assert (ar_log.size() == 1 && ar_log[0].len == 8'd0 && ar_log[0].size == sz)
            else report_mismatch("single read sent a wrong arlen or arsize");
    endtask

    task automatic line_write_back(input addr_t a, input int delay);
        data_line_t d;
        data_line_t got;
        int         oks;
        int         c;
        d   = {$urandom, $urandom, $urandom, $urandom};
        oks = wr_ok_count;
        b_delay <= delay;
        aw_log.delete();
        drive_write(a, 1'b1, 4'hf, d);
        drive_data_read(a, 1'b1, 3'd2, got, c);
        assert (got == d) else report_mismatch(
            $sformatf("line read after write got %h exp %h", got, d));
        assert (wr_ok_count == oks + 1) else report_mismatch(
            $sformatf("wr_ok pulsed %0d times", wr_ok_count - oks));
        assert (wr_ok_cycle < c) else report_mismatch("read returned before wr_ok");
        assert (aw_log.size() == 1 && aw_log[0].id == axi_id_t'(`DATA_ID)
                && aw_log[0].addr == a && aw_log[0].len == 8'd3 && aw_log[0].size == 3'd2)
            else report_mismatch("line write sent a wrong AW");
        b_delay <= 0;
    endtask

    task automatic partial_store();
        addr_t      a;
        word_t      nw;
        word_t      exp;
        strb_t      s;
        data_line_t got;
        int         c;
        a   = 32'h800 | ($urandom & 32'h3fc);
        nw  = $urandom;
        s   = strb_t'(1 + $urandom % 14);
        exp = merge_bytes(expected_word(a), nw, s);
        aw_log.delete();
        drive_write(a, 1'b0, s, {96'h0, nw});
        drive_data_read(a, 1'b0, 3'd2, got, c);
        assert (got[31:0] == exp) else report_mismatch(
            $sformatf("strobe %b write got %h exp %h", s, got[31:0], exp));
        assert (aw_log.size() == 1 && aw_log[0].id == axi_id_t'(`DATA_ID)
                && aw_log[0].addr == a && aw_log[0].len == 8'd0)
            else report_mismatch("single write sent a wrong AW");
    endtask

    task automatic same_cycle_reads();
        addr_t      ia;
        addr_t      da;
        inst_line_t ig;
        data_line_t dg;
        int         c;
        ia = $urandom & 32'h3e0;
        da = $urandom & 32'h3f0;
        ar_log.delete();
        fork
            drive_inst_read(ia, ig);
            drive_data_read(da, 1'b1, 3'd2, dg, c);
        join
        for (int k = 0; k < 8; k++) begin
            assert (ig[32*k +: 32] == expected_word(ia + addr_t'(4 * k)))
                else report_mismatch($sformatf("inst word %0d wrong after arbitration", k));
        end
        for (int k = 0; k < 4; k++) begin
            assert (dg[32*k +: 32] == expected_word(da + addr_t'(4 * k)))
                else report_mismatch($sformatf("data word %0d wrong after arbitration", k));
        end
        assert (ar_log.size() == 2 && ar_log[0].id == axi_id_t'(`DATA_ID)
                && ar_log[1].id == axi_id_t'(`INST_ID))
            else report_mismatch("data read did not reach AR first");
    endtask

    initial begin
        int n;
        inst_rd_req  = 1'b0;
        inst_rd_addr = '0;
        data_rd_req  = 1'b0;
        data_rd_type = 1'b0;
        data_rd_addr = '0;
        data_rd_size = '0;
        data_wr_req  = 1'b0;
        data_wr_type = 1'b0;
        data_wr_addr = '0;
        data_wr_strb = '0;
        data_wr_data = '0;
        b_delay      = 0;
        void'($urandom(32'h5e2a));

        for (n = 0; n < 20; n++) begin
            @(posedge aclk);
            if (!rst) break;
        end
        assert (n < 20) else report_timeout("reset was never released");
        assert (inst_rd_rdy && data_rd_rdy && data_wr_rdy && !arvalid && !awvalid
                && !wvalid && !rready && !bready && !inst_ret_valid && !data_ret_valid
                && !data_wr_ok)
            else report_mismatch("bridge not idle after reset");

        inst_refill();
        uncached_read();
        line_write_back(32'h400 | ($urandom & 32'h3f0), 0);
        partial_store();
        same_cycle_reads();
        // slow B keeps the line busy while the read waits
        line_write_back(32'hc00 | ($urandom & 32'h3f0), 10);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/axi_bridge_pkg.sv
verilog/rd_channel.sv
verilog/wr_channel.sv
verilog/axi_bridge_top.sv
verif/tb_clock_gen.sv
verif/axi_slave_model.sv
verif/tb_axi_bridge.sv

/* Makefile */
TOP := tb_axi_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
